// File: Makefile
# Verilator build and run of the field engine testbench
# Any variable can be overridden, for example: make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= field_engine_tb
FILELIST  ?= field_engine.f
TRACE     ?= sim/field_engine_trace.txt
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := ALL TESTS PASSED

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the simulator's exit status
run: $(SIM_BIN) $(TRACE)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed, log in $(LOG)"; \
	else \
		echo "Simulation failed, log in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: field_engine.f
rtl/fe_pkg.sv
rtl/operand_ram.sv
rtl/opr_fetch.sv
rtl/mod_alu.sv
rtl/field_engine.sv
sim/field_engine_tb.sv

// File: rtl/fe_pkg.sv
/*
 * Shared definitions for the 256-bit prime-field engine.
 * Holds widths, the SM2 modulus, the reset-constant addresses,
 * the opcode enum and the instruction and write-port structs.
 * Modules import it inside their body and use scoped names in port lists.
 */
`default_nettype none

package fe_pkg;

    ////////////////////////////////////////
    // Widths and depth

    localparam int FE_W     = 256;          // Field element width
    localparam int RF_AW    = 5;            // Register address width
    localparam int RF_DEPTH = 1 << RF_AW;   // 32 registers

    ////////////////////////////////////////
    // Field constants

    // SM2 prime, modulus of every add and sub
    localparam logic [FE_W-1:0] FIELD_P =
        256'hFFFFFFFE_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_00000000_FFFFFFFF_FFFFFFFF;

    localparam logic [RF_AW-1:0] ADDR_ZERO = 5'd18;   // Cleared at reset
    localparam logic [RF_AW-1:0] ADDR_ONE  = 5'd19;   // Set to one at reset

    ////////////////////////////////////////
    // Instruction format

    typedef enum logic [1:0] {
        OP_MOV  = 2'd0,     // dst = a
        OP_ADD  = 2'd1,     // dst = a + b mod p
        OP_SUB  = 2'd2,     // dst = a - b mod p
        OP_LOAD = 2'd3      // dst = imm
    } fe_op_e;

    typedef struct packed {
        fe_op_e             op;
        logic [RF_AW-1:0]   dst;
        logic [RF_AW-1:0]   src_a;
        logic [RF_AW-1:0]   src_b;
        logic [FE_W-1:0]    imm;    // Only used by OP_LOAD
    } fe_instr_t;

    // Register-file write port, driven by the ALU writeback
    typedef struct packed {
        logic               we;
        logic [RF_AW-1:0]   wa;
        logic [FE_W-1:0]    wd;
    } rf_wr_t;

endpackage

`default_nettype wire

// File: rtl/field_engine.sv
/*
 * Top level of the prime-field engine.
 * One instruction per cycle in, one result per instruction out,
 * fixed two-cycle latency. The ALU writeback loops back to the RF banks.
 */
`timescale 1ns/1ps
`default_nettype none

module field_engine
(
    input  wire logic                   clkw,
    input  wire logic                   rst,
    input  wire logic                   instr_valid,    // Single-cycle strobe
    input  wire fe_pkg::fe_instr_t      instr,
    output logic                        res_valid,
    output logic [fe_pkg::RF_AW-1:0]    res_addr,
    output logic [fe_pkg::FE_W-1:0]     res_data
);

    import fe_pkg::*;

    ////////////////////////////////////////
    // Stage wiring

    logic               ex_valid;
    fe_instr_t          ex_instr;
    logic [FE_W-1:0]    opa;
    logic [FE_W-1:0]    opb;
    rf_wr_t             rf_wr;      // Writeback loop

    opr_fetch i_opr_fetch
    (
        .clkw           (clkw),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .wr             (rf_wr),
        .ex_valid       (ex_valid),
        .ex_instr       (ex_instr),
        .opa            (opa),
        .opb            (opb)
    );

    mod_alu i_mod_alu
    (
        .clkw           (clkw),
        .rst            (rst),
        .ex_valid       (ex_valid),
        .ex_instr       (ex_instr),
        .opa            (opa),
        .opb            (opb),
        .wr             (rf_wr),
        .res_valid      (res_valid),
        .res_addr       (res_addr),
        .res_data       (res_data)
    );

endmodule

`default_nettype wire

// File: rtl/mod_alu.sv
/*
 * Execute and writeback stage.
 * Forwards its own last result for distance-one hazards, then does
 * modular add, modular sub, move or immediate load.
 * The registered result feeds both the result outputs and the RF write port.
 */
`timescale 1ns/1ps
`default_nettype none

module mod_alu
(
    input  wire logic                       clkw,
    input  wire logic                       rst,
    input  wire logic                       ex_valid,
    input  wire fe_pkg::fe_instr_t          ex_instr,
    input  wire logic [fe_pkg::FE_W-1:0]    opa,
    input  wire logic [fe_pkg::FE_W-1:0]    opb,
    output fe_pkg::rf_wr_t                  wr,         // To both RF banks
    output logic                            res_valid,
    output logic [fe_pkg::RF_AW-1:0]        res_addr,
    output logic [fe_pkg::FE_W-1:0]         res_data
);

    import fe_pkg::*;

    ////////////////////////////////////////
    // Result registers

    logic               vld_q;
    logic [RF_AW-1:0]   addr_q;
    logic [FE_W-1:0]    data_q;

    ////////////////////////////////////////
    // Forwarding

    logic [FE_W-1:0]    a_fwd;
    logic [FE_W-1:0]    b_fwd;

    // Previous result not yet in the RAM when issued back to back
    assign a_fwd = (vld_q && (addr_q == ex_instr.src_a)) ? data_q : opa;
    assign b_fwd = (vld_q && (addr_q == ex_instr.src_b)) ? data_q : opb;

    ////////////////////////////////////////
    // Modular arithmetic

    logic [FE_W:0]      sum;        // One carry bit
    logic [FE_W:0]      sum_red;    // Sum minus p
    logic [FE_W:0]      diff;       // Top bit is the borrow
    logic [FE_W-1:0]    diff_fix;   // Diff plus p
    logic [FE_W-1:0]    add_res;
    logic [FE_W-1:0]    sub_res;
    logic [FE_W-1:0]    alu_res;

    assign sum     = {1'b0, a_fwd} + {1'b0, b_fwd};
    assign sum_red = sum - {1'b0, FIELD_P};
    assign add_res = sum_red[FE_W] ? sum[FE_W-1:0] : sum_red[FE_W-1:0]; // Keep if sum < p

    assign diff     = {1'b0, a_fwd} - {1'b0, b_fwd};
    assign diff_fix = diff[FE_W-1:0] + FIELD_P;     // Wraps back into range
    assign sub_res  = diff[FE_W] ? diff_fix : diff[FE_W-1:0];

    // Opcode select
    always_comb
    begin
        case (ex_instr.op)
            OP_ADD:  alu_res = add_res;
            OP_SUB:  alu_res = sub_res;
            OP_MOV:  alu_res = a_fwd;
            OP_LOAD: alu_res = ex_instr.imm;
            default: alu_res = a_fwd;
        endcase
    end

    ////////////////////////////////////////
    // Writeback

    always_ff @(posedge clkw)
    begin
        if (rst)
            vld_q <= 1'b0;
        else
            vld_q <= ex_valid;
    end

    always_ff @(posedge clkw)
    begin
        addr_q <= ex_instr.dst;
        data_q <= alu_res;
    end

    assign res_valid = vld_q;
    assign res_addr  = addr_q;
    assign res_data  = data_q;

    // Same register drives the RF write, lands one edge later
    assign wr.we = vld_q;
    assign wr.wa = addr_q;
    assign wr.wd = data_q;

    // Immediates must already be reduced
    a_imm_reduced : assert property (@(posedge clkw) disable iff (rst)
        (ex_valid && (ex_instr.op == OP_LOAD)) |-> (ex_instr.imm < FIELD_P))
        else $error("mod_alu: loaded immediate not below p");

    // Nothing unreduced ever reaches the register file
    a_wd_reduced : assert property (@(posedge clkw) disable iff (rst)
        wr.we |-> (wr.wd < FIELD_P))
        else $error("mod_alu: write data not below p");

endmodule

`default_nettype wire

// File: rtl/operand_ram.sv
/*
 * 32 x 256 register file bank with one registered read port.
 * Read address registers on one edge, data on the next.
 * A write to the registered read address returns the write data.
 * Reset loads zero at address 18 and one at address 19.
 */
`timescale 1ns/1ps
`default_nettype none

module operand_ram
(
    input  wire logic                       clkw,
    input  wire logic                       rst,
    input  wire logic [fe_pkg::RF_AW-1:0]   ra,     // Read address
    output logic      [fe_pkg::FE_W-1:0]    rdo,    // Read data, two edges later
    input  wire fe_pkg::rf_wr_t             wr      // Writeback from the ALU
);

    import fe_pkg::*;

    ////////////////////////////////////////
    // Storage

    logic [FE_W-1:0]    mem [RF_DEPTH];
    logic [RF_AW-1:0]   ra_q;               // Registered read address
    logic [FE_W-1:0]    rd_q;               // Registered read data

    // Write port, reset constants take priority
    always_ff @(posedge clkw)
    begin
        if (rst)
        begin
            mem[ADDR_ZERO] <= '0;
            mem[ADDR_ONE]  <= FE_W'(1);
        end
        else if (wr.we)
        begin
            mem[wr.wa] <= wr.wd;
        end
    end

    ////////////////////////////////////////
    // Read path

    always_ff @(posedge clkw)
    begin
        ra_q <= ra;
        // Same-address bypass, array still holds the old word this edge
        if (wr.we && (wr.wa == ra_q))
            rd_q <= wr.wd;
        else
            rd_q <= mem[ra_q];
    end

    assign rdo = rd_q;

    // Write enable must be clean once out of reset
    a_we_known : assert property (@(posedge clkw) disable iff (rst)
        !$isunknown(wr.we))
        else $error("operand_ram: write enable unknown");

endmodule

`default_nettype wire

// File: rtl/opr_fetch.sv
/*
 * Fetch and operand read stages.
 * Two identical register-file banks give two read ports per cycle.
 * Both banks take the same writeback, so they always hold the same data.
 * Valid and instruction travel through two registers to line up with the reads.
 */
`timescale 1ns/1ps
`default_nettype none

module opr_fetch
(
    input  wire logic                   clkw,
    input  wire logic                   rst,
    input  wire logic                   instr_valid,
    input  wire fe_pkg::fe_instr_t      instr,
    input  wire fe_pkg::rf_wr_t         wr,         // Writeback to both banks
    output logic                        ex_valid,
    output fe_pkg::fe_instr_t           ex_instr,
    output logic [fe_pkg::FE_W-1:0]     opa,        // Operand from src_a
    output logic [fe_pkg::FE_W-1:0]     opb         // Operand from src_b
);

    import fe_pkg::*;

    ////////////////////////////////////////
    // Register-file banks

    operand_ram i_bank_a
    (
        .clkw   (clkw),
        .rst    (rst),
        .ra     (instr.src_a),
        .rdo    (opa),
        .wr     (wr)
    );

    operand_ram i_bank_b
    (
        .clkw   (clkw),
        .rst    (rst),
        .ra     (instr.src_b),
        .rdo    (opb),
        .wr     (wr)
    );

    ////////////////////////////////////////
    // Instruction delay, matches RAM latency

    logic       vld_q1;     // Fetch stage
    logic       vld_q2;     // Read stage
    fe_instr_t  instr_q1;
    fe_instr_t  instr_q2;

    // Control bits, cleared by reset
    always_ff @(posedge clkw)
    begin
        if (rst)
        begin
            vld_q1 <= 1'b0;
            vld_q2 <= 1'b0;
        end
        else
        begin
            vld_q1 <= instr_valid;
            vld_q2 <= vld_q1;
        end
    end

    // Payload follows unconditionally
    always_ff @(posedge clkw)
    begin
        instr_q1 <= instr;
        instr_q2 <= instr_q1;
    end

    assign ex_valid = vld_q2;
    assign ex_instr = instr_q2;

endmodule

`default_nettype wire

// File: sim/field_engine_tb.sv
/*
 * Testbench for the prime-field engine.
 * Reads instructions and expected results from the trace file, issues one
 * instruction per trace line and checks every result strobe for address,
 * data and the fixed two-cycle latency. Prints one line per test.
 */
`timescale 1ns/1ps
`default_nettype none

module field_engine_tb;

    import fe_pkg::*;

    ////////////////////////////////////////
    // Run limits

    localparam int    LATENCY     = 2;      // instr_valid to res_valid
    localparam int    DRAIN_LIMIT = 40;     // Cycles allowed for pending results
    localparam string TRACE_FILE  = "sim/field_engine_trace.txt";

    // One pending result
    typedef struct packed {
        logic [RF_AW-1:0]   addr;
        logic [FE_W-1:0]    data;
        logic [31:0]        due;    // Cycle count at which res_valid shows it
    } exp_t;

    ////////////////////////////////////////
    // DUT

    logic               clkw;
    logic               rst;
    logic               instr_valid;
    fe_instr_t          instr;
    logic               res_valid;
    logic [RF_AW-1:0]   res_addr;
    logic [FE_W-1:0]    res_data;

    field_engine i_field_engine
    (
        .clkw           (clkw),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .res_valid      (res_valid),
        .res_addr       (res_addr),
        .res_data       (res_data)
    );

    initial
    begin
        clkw = 1'b0;
        forever #10 clkw = ~clkw;   // 20 ns period
    end

    ////////////////////////////////////////
    // Scoreboard state

    exp_t   exp_q[$];               // Pending results, issue order
    exp_t   head;
    int     cycle        = 0;       // Rising edges seen so far
    string  cur_name     = "";
    int     cur_checks   = 0;
    int     cur_errs     = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     total_errs   = 0;

    always @(posedge clkw)
        cycle <= cycle + 1;

    // Outputs are stable at the falling edge
    always @(negedge clkw)
    begin
        if (!rst && $isunknown(res_valid))
        begin
            $display("res_valid is unknown after reset in test %s", cur_name);
            cur_errs++;
        end
        else if (res_valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Result for address %0d in test %s with nothing pending",
                         res_addr, cur_name);
                cur_errs++;
            end
            else
            begin
                head = exp_q.pop_front();
                cur_checks++;
                assert (res_addr === head.addr)
                else
                begin
                    $display("[ERROR] %s address: expected %0d, actual %0d",
                             cur_name, head.addr, res_addr);
                    cur_errs++;
                end
                assert (res_data === head.data)
                else
                begin
                    $display("[ERROR] %s data: expected %h, actual %h",
                             cur_name, head.data, res_data);
                    cur_errs++;
                end
                assert (32'(cycle) == head.due)   // Also proves one result per cycle
                else
                begin
                    $display("[ERROR] %s result cycle: expected %0d, actual %0d",
                             cur_name, head.due, cycle);
                    cur_errs++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Helpers

    // Opcode text from the trace, IDLE holds the bus quiet
    function automatic bit parse_op(input string s, output fe_op_e op, output bit idle);
        op   = OP_MOV;
        idle = 1'b0;
        case (s)
            "MOV":   op = OP_MOV;
            "ADD":   op = OP_ADD;
            "SUB":   op = OP_SUB;
            "LOAD":  op = OP_LOAD;
            "IDLE":  idle = 1'b1;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    // Drive one trace line on the next rising edge
    task automatic issue(input fe_op_e op, input bit idle, input logic [RF_AW-1:0] dst,
                         input logic [RF_AW-1:0] sa, input logic [RF_AW-1:0] sb,
                         input logic [FE_W-1:0] imm, input logic [FE_W-1:0] expv);
        fe_instr_t  ins;
        exp_t       e;
        @(posedge clkw);
        ins.op      = op;
        ins.dst     = dst;
        ins.src_a   = sa;
        ins.src_b   = sb;
        ins.imm     = imm;
        instr_valid <= !idle;
        instr       <= ins;
        if (!idle)
        begin
            e.addr = dst;
            e.data = expv;
            e.due  = 32'(cycle + 2 + LATENCY);    // Sampled next edge, cycle not yet bumped
            exp_q.push_back(e);
        end
    endtask

    // Stop issuing and wait for every pending result
    task automatic drain(output bit ok);
        int waited;
        waited = 0;
        @(posedge clkw);
        instr_valid <= 1'b0;
        while ((exp_q.size() != 0) && (waited < DRAIN_LIMIT))
        begin
            @(posedge clkw);
            waited++;
        end
        ok = (exp_q.size() == 0);
        if (!ok)
        begin
            $display("Timed out in test %s: %0d results never arrived",
                     cur_name, exp_q.size());
            cur_errs++;
        end
    endtask

    task automatic close_test();
        tests_run++;
        total_errs += cur_errs;
        if (cur_errs == 0)
            $display("PASS  %s  (%0d results)", cur_name, cur_checks);
        else
        begin
            tests_failed++;
            $display("FAIL  %s  (%0d results, %0d errors)", cur_name, cur_checks, cur_errs);
        end
        cur_checks = 0;
        cur_errs   = 0;
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial
    begin : drive_trace
        int                 fd;
        int                 n;
        string              line;
        string              name;
        string              op_s;
        fe_op_e             op;
        bit                 idle;
        bit                 ok;
        bit                 aborted;
        logic [RF_AW-1:0]   dst;
        logic [RF_AW-1:0]   sa;
        logic [RF_AW-1:0]   sb;
        logic [FE_W-1:0]    imm;
        logic [FE_W-1:0]    expv;

        rst         <= 1'b1;
        instr_valid <= 1'b0;
        instr       <= '0;
        aborted     = 1'b0;
        repeat (10) @(posedge clkw);
        rst <= 1'b0;

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file %s", TRACE_FILE);
            aborted = 1'b1;
        end
        else
        begin
            while (!$feof(fd) && !aborted)
            begin
                n = $fgets(line, fd);
                if ((n == 0) || (line.len() < 2) || (line.substr(0, 0) == "#"))
                    continue;                           // Blank or comment
                n = $sscanf(line, "%s %s %d %d %d %h %h", name, op_s, dst, sa, sb, imm, expv);
                if ((n != 7) || !parse_op(op_s, op, idle))
                begin
                    $display("Trace line could not be parsed: %s", line);
                    aborted = 1'b1;
                end
                else
                begin
                    if (name != cur_name)
                    begin
                        // New test, finish the previous one first
                        if (cur_name != "")
                        begin
                            drain(ok);
                            close_test();
                            aborted = !ok;
                        end
                        cur_name = name;
                    end
                    if (!aborted)
                        issue(op, idle, dst, sa, sb, imm, expv);
                end
            end
            $fclose(fd);
        end

        if (!aborted && (cur_name != ""))
        begin
            drain(ok);
            close_test();
            aborted = !ok;
        end

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, total_errs);
        if (!aborted && (tests_run > 0) && (total_errs == 0))
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/field_engine_trace.txt
# Columns: test op dst src_a src_b imm(hex) expected(hex); dst and sources in decimal
# IDLE lines keep instr_valid low for one cycle and expect no result
reset_const MOV 1 18 18 0 0
reset_const MOV 2 19 19 0 1
load_copy LOAD 3 0 0 123456789abcdef0 123456789abcdef0
load_copy LOAD 7 0 0 1 1
load_copy LOAD 11 0 0 a a
load_copy LOAD 15 0 0 5 5
load_copy MOV 5 3 3 0 123456789abcdef0
load_copy MOV 6 11 11 0 a
sub_mod SUB 14 3 3 0 0
sub_mod SUB 4 18 19 0 fffffffeffffffffffffffffffffffffffffffff00000000fffffffffffffffe
sub_mod SUB 10 18 15 0 fffffffeffffffffffffffffffffffffffffffff00000000fffffffffffffffa
sub_mod SUB 16 7 11 0 fffffffeffffffffffffffffffffffffffffffff00000000fffffffffffffff6
sub_mod SUB 17 11 7 0 9
add_mod ADD 8 3 7 0 123456789abcdef1
add_mod ADD 9 4 7 0 0
add_mod ADD 12 10 11 0 5
add_mod ADD 13 4 4 0 fffffffeffffffffffffffffffffffffffffffff00000000fffffffffffffffd
hazard_d1 LOAD 20 0 0 5 5
hazard_d1 ADD 20 20 7 0 6
hazard_d1 ADD 20 20 20 0 c
hazard_d1 ADD 21 20 7 0 d
hazard_d1 LOAD 26 0 0 1 1
hazard_d1 LOAD 26 0 0 2 2
hazard_d1 MOV 27 26 26 0 2
hazard_d2 LOAD 22 0 0 64 64
hazard_d2 IDLE 0 0 0 0 0
hazard_d2 ADD 22 22 22 0 c8
hazard_d2 IDLE 0 0 0 0 0
hazard_d2 ADD 23 22 7 0 c9
hazard_d3 LOAD 24 0 0 ff ff
hazard_d3 IDLE 0 0 0 0 0
hazard_d3 IDLE 0 0 0 0 0
hazard_d3 ADD 24 24 7 0 100
burst LOAD 28 0 0 a1 a1
burst LOAD 29 0 0 b2 b2
burst LOAD 30 0 0 c3 c3
burst MOV 31 19 19 0 1
burst ADD 0 18 19 0 1
burst SUB 1 19 18 0 1
burst LOAD 2 0 0 d4 d4
